//--- design/branchControl.sv
// Stack sequencing and branch record register, giving the one-cycle output of branchUnit
`timescale 1ns/1ps

module branchControl (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          inValid,
  input  branchPkg::decodeInfo          info,
  input  logic [branchPkg::ipWidth-1:0] pc,
  input  logic [branchPkg::ipWidth-1:0] target,
  input  logic [branchPkg::ipWidth-1:0] returnAddr,
  input  logic                          stackEmpty,
  output logic                          push,
  output logic                          pop,
  output logic [branchPkg::ipWidth-1:0] pushAddr,
  output logic                          outValid,
  output branchPkg::branchRecord        record,
  output logic                          redirect
);

  branchPkg::branchRecord nextRecord;
  logic                   nextRedirect;

  // Stack operations land on the same edge that captures the record
  assign push     = inValid & info.isJump & info.isCall;
  assign pop      = inValid & info.isJump & info.isRet;
  assign pushAddr = returnAddr;

  assign nextRedirect = inValid & info.isJump & info.jumpType[4];

  always_comb begin
    nextRecord.pc       = pc;
    // A non-jump reports its fall-through address
    nextRecord.target   = info.isJump ? target : returnAddr;
    nextRecord.jumpType = info.isJump ? info.jumpType : branchPkg::jtNone;
    nextRecord.isCall   = info.isJump & info.isCall;
    nextRecord.isRet    = info.isJump & info.isRet;
    nextRecord.retMiss  = info.isJump & info.isRet & stackEmpty;
    nextRecord.error    = info.error;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
      redirect <= 1'b0;
    end else begin
      outValid <= inValid;
      redirect <= nextRedirect;
    end
  end

  // The record keeps its last value through bubbles
  always_ff @(posedge clk) begin
    if (inValid) begin
      record <= nextRecord;
    end
  end

endmodule

//--- design/branchPkg.sv
// Shared widths, jump type codes and record types for the branch decode stage
package branchPkg;

  // Instruction window and address sizes
  localparam int instrWidth    = 80;
  localparam int ipWidth       = 48;
  localparam int magicWidth    = 4;
  localparam int jumpTypeWidth = 5;
  localparam int dispWidth     = 64;
  localparam int lenWidth      = 4;

  // Return address stack geometry
  localparam int stackDepth    = 8;
  localparam int stackPtrWidth = 3;

  // Bit 4 set marks a transfer that always redirects fetch
  localparam logic [jumpTypeWidth-1:0] jtUncond = 5'h10;
  localparam logic [jumpTypeWidth-1:0] jtIndir  = 5'h11;
  // Only meaningful when isJump is low
  localparam logic [jumpTypeWidth-1:0] jtNone   = 5'h10;

  // Instruction length in bytes for each length code
  localparam logic [lenWidth-1:0] len2 = 4'd2;
  localparam logic [lenWidth-1:0] len4 = 4'd4;
  localparam logic [lenWidth-1:0] len6 = 4'd6;
  localparam logic [lenWidth-1:0] len8 = 4'd8;

  // Combinational decode result for one instruction
  typedef struct packed {
    logic                         isJump;
    logic                         isIndir;
    logic                         isCall;
    logic                         isRet;
    logic [jumpTypeWidth-1:0]     jumpType;
    logic signed [dispWidth-1:0]  disp;
    logic [lenWidth-1:0]          length;
    logic                         error;
  } decodeInfo;

  // Registered branch report, one per accepted instruction
  typedef struct packed {
    logic [ipWidth-1:0]       pc;
    logic [ipWidth-1:0]       target;
    logic [jumpTypeWidth-1:0] jumpType;
    logic                     isCall;
    logic                     isRet;
    logic                     retMiss;
    logic                     error;
  } branchRecord;

endpackage

//--- design/branchUnit.sv
// Top of the branch decode stage, taking one instruction per cycle and reporting it a cycle later
`timescale 1ns/1ps

module branchUnit (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             inValid,
  input  logic [branchPkg::instrWidth-1:0] instr,
  input  logic [branchPkg::magicWidth-1:0] magic,
  input  logic [branchPkg::ipWidth-1:0]    pc,
  input  logic [branchPkg::ipWidth-1:0]    indirTarget,
  input  logic                             condSense,
  output logic                             outValid,
  output branchPkg::branchRecord           record,
  output logic                             redirect
);

  branchPkg::decodeInfo          info;
  logic [branchPkg::ipWidth-1:0] target;
  logic [branchPkg::ipWidth-1:0] returnAddr;
  logic [branchPkg::ipWidth-1:0] stackTop;
  logic [branchPkg::ipWidth-1:0] pushAddr;
  logic                          stackEmpty;
  logic                          push;
  logic                          pop;

  jumpDecoder decoder_i (
    .instr     (instr),
    .magic     (magic),
    .condSense (condSense),
    .info      (info)
  );

  targetCalc target_i (
    .info        (info),
    .pc          (pc),
    .indirTarget (indirTarget),
    .stackTop    (stackTop),
    .target      (target),
    .returnAddr  (returnAddr)
  );

  returnStack stack_i (
    .clk      (clk),
    .rstN     (rstN),
    .push     (push),
    .pop      (pop),
    .pushAddr (pushAddr),
    .top      (stackTop),
    .empty    (stackEmpty)
  );

  branchControl control_i (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .info       (info),
    .pc         (pc),
    .target     (target),
    .returnAddr (returnAddr),
    .stackEmpty (stackEmpty),
    .push       (push),
    .pop        (pop),
    .pushAddr   (pushAddr),
    .outValid   (outValid),
    .record     (record),
    .redirect   (redirect)
  );

endmodule

//--- design/jumpDecoder.sv
// Combinational jump classifier, used by branchUnit to decode one aligned instruction per cycle
`timescale 1ns/1ps

module jumpDecoder (
  input  logic [branchPkg::instrWidth-1:0] instr,
  input  logic [branchPkg::magicWidth-1:0] magic,
  input  logic                             condSense,
  output branchPkg::decodeInfo             info
);

  logic [7:0] opcode;
  logic [branchPkg::lenWidth-1:0] lenBytes;
  logic signed [branchPkg::dispWidth-1:0] wideDisp;
  logic isShortCond;
  logic isBasicCond;
  logic isLongCond;
  logic isUncond;
  logic isIndirJump;
  logic isCallJump;
  logic isRetJump;
  logic badMagic;
  logic longForm;

  assign opcode = instr[7:0];

  // Length code decodes from the low bits up
  always_comb begin
    if (!magic[0]) begin
      lenBytes = branchPkg::len2;
    end else if (magic[1:0] == 2'b01) begin
      lenBytes = branchPkg::len4;
    end else if (magic[2:0] == 3'b011) begin
      lenBytes = branchPkg::len6;
    end else begin
      lenBytes = branchPkg::len8;
    end
  end

  assign badMagic = (magic == 4'b1111);
  assign longForm = (magic == 4'b0111);

  // Default 32-bit displacement of the 6-byte forms
  assign wideDisp = {{32{instr[47]}}, instr[47:17], 1'b0};

  // Short forms only exist in the 2-byte encoding, everything else needs magic bit 0
  assign isShortCond = ~magic[0] & (opcode[5:2] == 4'b1100);
  assign isBasicCond = magic[0] & (opcode[7:4] == 4'hA);
  assign isLongCond  = magic[0] & (opcode == 8'hB4);
  assign isUncond    = magic[0] & (opcode == 8'hB5);
  assign isIndirJump = magic[0] & (opcode == 8'hB6) & (instr[15:13] == 3'd0);
  assign isCallJump  = magic[0] & (opcode == 8'hB6) &
                       ((instr[15:13] == 3'd1) | (instr[15:13] == 3'd2));
  assign isRetJump   = magic[0] & (opcode == 8'hB6) & (instr[15:13] == 3'd3);

  always_comb begin
    info          = '0;
    info.jumpType = branchPkg::jtNone;
    info.disp     = wideDisp;
    info.length   = lenBytes;
    info.isJump   = isShortCond | isBasicCond | isLongCond | isUncond |
                    isIndirJump | isCallJump | isRetJump;
    // Only basic conditionals and unconditionals have an 8-byte form
    info.error    = badMagic |
                    (info.isJump & longForm & ~(isBasicCond | isUncond));

    if (isShortCond) begin
      info.disp     = {{55{instr[15]}}, instr[15:8], 1'b0};
      info.jumpType = {1'b0, instr[7:6], instr[1:0]};
      // Code F would be "never", so it is reused as a short unconditional
      if ({instr[7:6], instr[1:0]} == 4'hF) begin
        info.jumpType = branchPkg::jtUncond;
      end
    end else if (isBasicCond) begin
      info.jumpType = {1'b0, (magic[1:0] == 2'b01) ? instr[18] : instr[32],
                       opcode[3:2], opcode[1] ^ condSense};
      if (magic[1:0] == 2'b01) begin
        info.disp = {{50{instr[31]}}, instr[31:19], 1'b0};
      end else if (magic[2:0] == 3'b011) begin
        info.disp = {{48{instr[47]}}, instr[47:33], 1'b0};
      end else begin
        info.disp = {{32{instr[63]}}, instr[63:33], 1'b0};
      end
    end else if (isLongCond) begin
      info.jumpType = {1'b0, instr[11:9], instr[8] ^ condSense};
      if (magic[1:0] == 2'b01) begin
        info.disp = {{43{instr[31]}}, instr[31:12], 1'b0};
      end
    end else if (isUncond) begin
      info.jumpType = branchPkg::jtUncond;
      if (magic[1:0] == 2'b01) begin
        info.disp = {{39{instr[31]}}, instr[31:8], 1'b0};
      end else if (longForm) begin
        info.disp = {{16{instr[63]}}, instr[63:17], 1'b0};
      end
    end else if (isIndirJump) begin
      info.isIndir  = 1'b1;
      info.jumpType = branchPkg::jtIndir;
    end else if (isCallJump) begin
      info.isCall   = 1'b1;
      info.jumpType = branchPkg::jtUncond;
      if (magic[1:0] == 2'b01) begin
        info.disp = {{47{instr[31]}}, instr[31:16], 1'b0};
      end
    end else if (isRetJump) begin
      info.isRet    = 1'b1;
      info.jumpType = branchPkg::jtIndir;
    end
  end

endmodule

//--- design/returnStack.sv
// Circular return address stack, pushed by calls and popped by returns in branchUnit
`timescale 1ns/1ps

module returnStack (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          push,
  input  logic                          pop,
  input  logic [branchPkg::ipWidth-1:0] pushAddr,
  output logic [branchPkg::ipWidth-1:0] top,
  output logic                          empty
);

  logic [branchPkg::ipWidth-1:0] entries [branchPkg::stackDepth];
  // Pointer names the next free slot and wraps around the array
  logic [branchPkg::stackPtrWidth-1:0] ptr;
  logic [branchPkg::stackPtrWidth-1:0] topIdx;
  logic [branchPkg::stackPtrWidth:0]   count;
  logic                                full;

  assign topIdx = ptr - 1'b1;
  assign empty  = (count == '0);
  assign full   = (count == (branchPkg::stackPtrWidth + 1)'(branchPkg::stackDepth));

  // Empty stack reads back as zero
  assign top = empty ? '0 : entries[topIdx];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ptr   <= '0;
      count <= '0;
    end else if (push) begin
      ptr <= ptr + 1'b1;
      // Once full, a push overwrites the oldest entry and the count holds
      if (!full) begin
        count <= count + 1'b1;
      end
    end else if (pop && !empty) begin
      ptr   <= topIdx;
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[ptr] <= pushAddr;
    end
  end

endmodule

//--- design/targetCalc.sv
// Branch target and return address adders for the branch decode stage
`timescale 1ns/1ps

module targetCalc (
  input  branchPkg::decodeInfo          info,
  input  logic [branchPkg::ipWidth-1:0] pc,
  input  logic [branchPkg::ipWidth-1:0] indirTarget,
  input  logic [branchPkg::ipWidth-1:0] stackTop,
  output logic [branchPkg::ipWidth-1:0] target,
  output logic [branchPkg::ipWidth-1:0] returnAddr
);

  logic [branchPkg::ipWidth-1:0] dispTarget;
  logic [branchPkg::ipWidth-1:0] lenExt;

  // Displacement is truncated to the address width, so the sum wraps
  assign dispTarget = pc + info.disp[branchPkg::ipWidth-1:0];

  assign lenExt     = {{(branchPkg::ipWidth - branchPkg::lenWidth){1'b0}}, info.length};
  assign returnAddr = pc + lenExt;

  always_comb begin
    if (info.isRet) begin
      target = stackTop;
    end else if (info.isIndir) begin
      target = indirTarget;
    end else begin
      target = dispTarget;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench and judge the result from the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module branchUnit_tb \
  -o branchUnitSim > build.log 2>&1 \
  && ./obj_dir/branchUnitSim > sim.log 2>&1 \
  || echo "Build or simulation ended with an error" >> sim.log
cat build.log sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

//--- sources.f
design/branchPkg.sv
design/jumpDecoder.sv
design/returnStack.sv
design/targetCalc.sv
design/branchControl.sv
design/branchUnit.sv
testbench/branchUnit_sva.sv
testbench/branchUnit_tb.sv

//--- testbench/branchUnit_sva.sv
// Concurrent checks on redirect and return stack control, bound into every branchUnit
`timescale 1ns/1ps

module branchUnit_sva (
  input logic clk,
  input logic rstN,
  input logic outValid,
  input logic redirect,
  input logic push,
  input logic pop
);

  // A redirect always belongs to a reported record
  redirectHasRecord: assert property (@(posedge clk) disable iff (!rstN) redirect |-> outValid)
    else $error("redirect is high without outValid");

  stackOpExclusive: assert property (@(posedge clk) disable iff (!rstN) !(push && pop))
    else $error("push and pop are high in the same cycle");

  // The record strobe stays quiet for the whole reset
  quietInReset: assert property (@(posedge clk) !rstN |-> !outValid)
    else $error("outValid is high during reset");

endmodule

bind branchUnit branchUnit_sva sva_i (
  .clk      (clk),
  .rstN     (rstN),
  .outValid (outValid),
  .redirect (redirect),
  .push     (push),
  .pop      (pop)
);

//--- testbench/branchUnit_tb.sv
// Table-driven testbench for branchUnit, run as the simulation top with a return stack model
`timescale 1ns/1ps

module branchUnit_tb;

  typedef enum logic [2:0] {
    kindNone, kindBubble, kindJump, kindCall, kindRet, kindIndir
  } entryKind;

  // Expected target is formed from the row kind when the row is checked
  typedef struct packed {
    logic [branchPkg::instrWidth-1:0]    instr;
    logic [branchPkg::magicWidth-1:0]    magic;
    logic                                condSense;
    entryKind                            kind;
    logic [branchPkg::jumpTypeWidth-1:0] expType;
    logic [branchPkg::ipWidth-1:0]       disp;
    logic [branchPkg::lenWidth-1:0]      len;
  } stimRow;

  logic                             clk = 1'b0;
  logic                             rstN;
  logic                             inValid;
  logic [branchPkg::instrWidth-1:0] instr;
  logic [branchPkg::magicWidth-1:0] magic;
  logic [branchPkg::ipWidth-1:0]    pc;
  logic [branchPkg::ipWidth-1:0]    indirTarget;
  logic                             condSense;
  logic                             outValid;
  branchPkg::branchRecord           record;
  logic                             redirect;

  stimRow                        rows[$];
  string                         names[$];
  logic [branchPkg::ipWidth-1:0] pcs[$];
  logic [branchPkg::ipWidth-1:0] indirs[$];
  int                            tableLen = 0;

  // Reference return stack, circular with a saturating count
  logic [branchPkg::ipWidth-1:0] modelMem [branchPkg::stackDepth];
  int                            modelPtr = 0;
  int                            modelCount = 0;

  branchUnit dut_i (.*);

  always #20 clk = ~clk;

  function automatic logic [branchPkg::ipWidth-1:0] randomAddr();
    logic [63:0] raw;
    raw = {$urandom(), $urandom()};
    return raw[branchPkg::ipWidth-1:0];
  endfunction

  task automatic addRow(input string name, input logic [branchPkg::instrWidth-1:0] rowInstr,
                        input logic [branchPkg::magicWidth-1:0] rowMagic, input logic rowSense,
                        input entryKind kind, input logic [branchPkg::jumpTypeWidth-1:0] expType,
                        input logic [branchPkg::ipWidth-1:0] disp,
                        input logic [branchPkg::lenWidth-1:0] len);
    names.push_back(name);
    rows.push_back({rowInstr, rowMagic, rowSense, kind, expType, disp, len});
  endtask

  task automatic reportMismatch(input string name, input string what,
                                input logic [63:0] expected, input logic [63:0] actual);
    $display("[FAIL] %s: %s expected %h, actual %h", name, what, expected, actual);
    $display("TESTS FAILED");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic checkRow(input int j);
    stimRow                        r;
    string                         n;
    logic [branchPkg::ipWidth-1:0] expTarget;
    logic                          expMiss;
    logic                          expRedirect;
    r = rows[j];
    n = names[j];
    expTarget = '0;
    expMiss = 1'b0;
    case (r.kind)
      kindJump, kindCall: expTarget = pcs[j] + r.disp;
      kindIndir: expTarget = indirs[j];
      kindRet: begin
        // A pop on an empty stack reads zero and flags a miss
        if (modelCount == 0) begin
          expMiss = 1'b1;
        end else begin
          modelPtr = (modelPtr + branchPkg::stackDepth - 1) % branchPkg::stackDepth;
          modelCount--;
          expTarget = modelMem[modelPtr];
        end
      end
      default: expTarget = '0;
    endcase
    if (r.kind == kindCall) begin
      modelMem[modelPtr] = pcs[j] + {{(branchPkg::ipWidth - branchPkg::lenWidth){1'b0}}, r.len};
      modelPtr = (modelPtr + 1) % branchPkg::stackDepth;
      if (modelCount < branchPkg::stackDepth) begin
        modelCount++;
      end
    end
    // Only a valid jump whose type has bit 4 set redirects fetch
    expRedirect = (r.kind != kindNone) && (r.kind != kindBubble) && r.expType[4];
    assert (redirect == expRedirect)
      else reportMismatch(n, "redirect", 64'(expRedirect), 64'(redirect));
    if (r.kind == kindBubble) begin
      assert (!outValid) else reportMismatch(n, "outValid", 64'd0, 64'(outValid));
    end else begin
      assert (outValid) else reportMismatch(n, "outValid", 64'd1, 64'(outValid));
      assert (record.pc == pcs[j]) else reportMismatch(n, "pc", 64'(pcs[j]), 64'(record.pc));
      assert (record.jumpType == r.expType)
        else reportMismatch(n, "jumpType", 64'(r.expType), 64'(record.jumpType));
      assert (r.kind == kindNone || record.target == expTarget)
        else reportMismatch(n, "target", 64'(expTarget), 64'(record.target));
      assert (record.isCall == (r.kind == kindCall))
        else reportMismatch(n, "isCall", 64'(r.kind == kindCall), 64'(record.isCall));
      assert (record.isRet == (r.kind == kindRet))
        else reportMismatch(n, "isRet", 64'(r.kind == kindRet), 64'(record.isRet));
      assert (record.retMiss == expMiss)
        else reportMismatch(n, "retMiss", 64'(expMiss), 64'(record.retMiss));
      assert (!record.error) else reportMismatch(n, "error", 64'd0, 64'(record.error));
    end
  endtask

  task automatic buildTable();
    int k;
    // Short form ignores condSense, and its code F becomes an unconditional jump
    addRow("shortCc5Cs0", 80'h1071, 4'h0, 1'b0, kindJump, 5'h05, 48'sd32, 4'd2);
    addRow("shortCc5Cs1", 80'h1071, 4'h0, 1'b1, kindJump, 5'h05, 48'sd32, 4'd2);
    addRow("shortCcF", 80'hF0F3, 4'h0, 1'b0, kindJump, 5'h10, -48'sd32, 4'd2);
    addRow("basic4Cs0", 80'h020400A6, 4'h1, 1'b0, kindJump, 5'h0B, 48'sd128, 4'd4);
    addRow("basic4Cs1", 80'h020400A6, 4'h1, 1'b1, kindJump, 5'h0A, 48'sd128, 4'd4);
    addRow("basic6Cs0", 80'hFFE0000000A8, 4'h3, 1'b0, kindJump, 5'h04, -48'sd32, 4'd6);
    addRow("basic6Cs1", 80'hFFE0000000A8, 4'h3, 1'b1, kindJump, 5'h05, -48'sd32, 4'd6);
    addRow("long4Cs0", 80'h001007B4, 4'h1, 1'b0, kindJump, 5'h07, 48'sh200, 4'd4);
    addRow("long4Cs1", 80'h001007B4, 4'h1, 1'b1, kindJump, 5'h06, 48'sh200, 4'd4);
    addRow("long6Cs0", 80'hFFFFFE0003B4, 4'h3, 1'b0, kindJump, 5'h03, -48'sh200, 4'd6);
    addRow("long6Cs1", 80'hFFFFFE0003B4, 4'h3, 1'b1, kindJump, 5'h02, -48'sh200, 4'd6);
    addRow("uncond4", 80'hFFFFC0B5, 4'h1, 1'b0, kindJump, 5'h10, -48'sh80, 4'd4);
    addRow("uncond6", 80'h200000B5, 4'h3, 1'b0, kindJump, 5'h10, 48'sh2000, 4'd6);
    addRow("uncond8", 80'hFFFFFFFF000000B5, 4'h7, 1'b0, kindJump, 5'h10, -48'sh10000, 4'd8);
    addRow("indirect", 80'h00B6, 4'h1, 1'b0, kindIndir, 5'h11, 48'sh0, 4'd4);
    addRow("nonJump", 80'h0090, 4'h1, 1'b0, kindNone, 5'h10, 48'sh0, 4'd4);
    // A call pattern inside a bubble must never reach the stack
    addRow("bubble", 80'h010020B6, 4'h1, 1'b0, kindBubble, 5'h10, 48'sh0, 4'd4);
    addRow("callOuter", 80'h010020B6, 4'h1, 1'b0, kindCall, 5'h10, 48'sh200, 4'd4);
    addRow("callInner", 80'h040040B6, 4'h3, 1'b0, kindCall, 5'h10, 48'sh400, 4'd6);
    addRow("retInner", 80'h60B6, 4'h1, 1'b0, kindRet, 5'h11, 48'sh0, 4'd4);
    addRow("retOuter", 80'h60B6, 4'h1, 1'b0, kindRet, 5'h11, 48'sh0, 4'd4);
    // A return on the drained stack misses unless the bubble leaked a push
    addRow("retEmpty", 80'h60B6, 4'h1, 1'b0, kindRet, 5'h11, 48'sh0, 4'd4);
    // Nine calls overflow eight entries, so the ninth return misses
    for (k = 0; k < 9; k++) begin
      addRow($sformatf("deepCall%0d", k), 80'hFF0020B6, 4'h1, 1'b0, kindCall, 5'h10,
             -48'sh200, 4'd4);
    end
    for (k = 0; k < 9; k++) begin
      addRow($sformatf("deepRet%0d", k), 80'h60B6, 4'h1, 1'b0, kindRet, 5'h11, 48'sh0, 4'd4);
    end
  endtask

  initial begin
    int     idx;
    stimRow r;
    void'($urandom(87));
    rstN = 1'b0;
    inValid = 1'b0;
    instr = '0;
    magic = '0;
    pc = '0;
    indirTarget = '0;
    condSense = 1'b0;
    buildTable();
    tableLen = rows.size();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    // Each row is checked one cycle after it is driven, so rows follow back to back
    for (idx = 0; idx <= tableLen; idx++) begin
      @(negedge clk);
      if (idx > 0) begin
        checkRow(idx - 1);
      end
      if (idx < tableLen) begin
        r = rows[idx];
        pcs.push_back(randomAddr());
        indirs.push_back(randomAddr());
        inValid = (r.kind != kindBubble);
        instr = r.instr;
        magic = r.magic;
        condSense = r.condSense;
        pc = pcs[idx];
        indirTarget = indirs[idx];
      end else begin
        inValid = 1'b0;
      end
    end
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    wait (tableLen != 0);
    // Reset, every table row and a margin, all in 40 ns clock periods
    #((tableLen + 10) * 40);
    $display("Timeout: the run did not finish within %0d clock periods", tableLen + 10);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule
